/* Makefile */
# Verilator build and run for the auto-zero front end testbench

VERILATOR ?= verilator
TOP       ?= tb_az_frontend
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# pass only when the pass line shows up in the simulation output
run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* src/az_frontend_top.sv */
// auto-zero acquisition front end top level
// sequencer drives the az mux, pre-charge switch and adc reset,
// capture block hands tagged adc words to the host on credits

`timescale 1ns/10ps

module az_frontend_top import az_pkg::*; #(
  parameter int DATA_W  = 24,
  parameter int CREDITS = 4
) (
  input  logic               clk,
  input  logic               arst_n_i,

  // configuration, static while running
  input  logic [AZMUX_W-1:0] azmux_lo_val_i,
  input  logic [AZMUX_W-1:0] azmux_hi_val_i,
  input  logic [SW_PC_W-1:0] sw_pc_hi_val_i,
  input  logic [CNT_W-1:0]   settle_count_i,

  input  logic               arm_trigger_i,

  // adc
  input  logic               adc_valid_i,
  input  logic [DATA_W-1:0]  adc_data_i,
  output logic               adc_reset_n_o,

  // analog switches
  output logic [AZMUX_W-1:0] azmux_o,
  output logic [SW_PC_W-1:0] sw_pc_o,

  // host side
  output logic               result_valid_o,
  output logic               result_tag_o,
  output logic [DATA_W-1:0]  result_data_o,
  input  logic               credit_return_i
);

  logic sample_tag;
  logic slot_free;

  az_sequencer seq_i (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .azmux_lo_val_i (azmux_lo_val_i),
    .azmux_hi_val_i (azmux_hi_val_i),
    .sw_pc_hi_val_i (sw_pc_hi_val_i),
    .settle_count_i (settle_count_i),
    .arm_trigger_i  (arm_trigger_i),
    .adc_valid_i    (adc_valid_i),
    .slot_free_i    (slot_free),
    .adc_reset_n_o  (adc_reset_n_o),
    .azmux_o        (azmux_o),
    .sw_pc_o        (sw_pc_o),
    .sample_tag_o   (sample_tag)
  );

  // capture watches the same adc reset line to reserve credits
  az_result_capture #(
    .DATA_W  (DATA_W),
    .CREDITS (CREDITS)
  ) cap_i (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .adc_reset_n_i   (adc_reset_n_o),
    .adc_valid_i     (adc_valid_i),
    .adc_data_i      (adc_data_i),
    .sample_tag_i    (sample_tag),
    .credit_return_i (credit_return_i),
    .slot_free_o     (slot_free),
    .result_valid_o  (result_valid_o),
    .result_tag_o    (result_tag_o),
    .result_data_o   (result_data_o)
  );

endmodule : az_frontend_top

/* src/az_pkg.sv */
// auto-zero front end shared definitions
// pre-charge switch codes, sample tag values and field widths
// used by the sequencer, the capture block and the top level

package az_pkg;

  ////////////////////////////////////////////////////////////
  // field widths

  // az mux select, one-hot or encoded as the board wants
  localparam int AZMUX_W = 4;

  // pre-charge switch control
  localparam int SW_PC_W = 2;

  // settle down-counter, enough for a few hundred ms at tens of MHz
  localparam int CNT_W = 24;

  ////////////////////////////////////////////////////////////
  // pre-charge switch codes

  // boot protects the signal node from az mux charge injection
  // signal is the usual code for the hi sample, but the actual
  // hi code comes in from configuration
  typedef enum logic [SW_PC_W-1:0] {
    SW_PC_BOOT   = 2'b00,
    SW_PC_SIGNAL = 2'b01
  } sw_pc_e;

  ////////////////////////////////////////////////////////////
  // sample tag

  // carried with every result word
  // hi is the signal input, lo is the zero reference
  localparam logic SAMPLE_HI = 1'b1;
  localparam logic SAMPLE_LO = 1'b0;

endpackage : az_pkg

/* src/az_result_capture.sv */
// result capture for the auto-zero front end
// latches each adc word on valid, tags it hi or lo and presents it
// to the host for one cycle, under credit flow control
// a credit is reserved when the adc leaves reset

`timescale 1ns/10ps

module az_result_capture #(
  parameter int DATA_W  = 24,
  parameter int CREDITS = 4
) (
  input  logic              clk,
  input  logic              arst_n_i,

  input  logic              adc_reset_n_i,
  input  logic              adc_valid_i,
  input  logic [DATA_W-1:0] adc_data_i,
  input  logic              sample_tag_i,
  input  logic              credit_return_i,

  output logic              slot_free_o,
  output logic              result_valid_o,
  output logic              result_tag_o,
  output logic [DATA_W-1:0] result_data_o
);

  // enough bits to hold 0 .. CREDITS
  localparam int CRED_W = $clog2(CREDITS + 1);

  logic [CRED_W-1:0] credit_cnt_q;
  logic              reserved_q;
  logic              adc_reset_n_q;
  logic              conv_start;
  logic              in_flight;
  logic              capture;
  logic              pending;

  logic              result_valid_q;
  logic              result_tag_q;
  logic [DATA_W-1:0] result_data_q;

  ////////////////////////////////////////////////////////////
  // conversion tracking

  // rising edge of adc reset release marks a new conversion
  assign conv_start = adc_reset_n_i & ~adc_reset_n_q;
  assign in_flight  = reserved_q | conv_start;

  // valid only counts while the adc is running on a reserved slot
  assign capture    = adc_valid_i & adc_reset_n_i & in_flight;

  // credit held by a conversion or by a result not yet spent
  assign pending    = reserved_q | result_valid_q;

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      adc_reset_n_q <= 1'b0;
      reserved_q    <= 1'b0;
    end
    else
    begin
      adc_reset_n_q <= adc_reset_n_i;
      if (capture)
        reserved_q <= 1'b0;
      else if (conv_start)
        reserved_q <= 1'b1;
      // adc pulled back into reset without a result, drop the slot
      else if (!adc_reset_n_i)
        reserved_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // credit counter

  // spent on each result pulse, returned one per host return cycle
  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      credit_cnt_q <= CRED_W'(CREDITS);
    else
    begin
      case ({result_valid_q, credit_return_i})
        2'b10:   credit_cnt_q <= credit_cnt_q - 1'b1;
        2'b01:   credit_cnt_q <= credit_cnt_q + 1'b1;
        default: credit_cnt_q <= credit_cnt_q;
      endcase
    end
  end

  assign slot_free_o = (credit_cnt_q > CRED_W'(pending));

  ////////////////////////////////////////////////////////////
  // output register

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      result_valid_q <= 1'b0;
    else
      result_valid_q <= capture;
  end

  // payload only
  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      result_data_q <= adc_data_i;
      result_tag_q  <= sample_tag_i;
    end
  end

  assign result_valid_o = result_valid_q;
  assign result_tag_o   = result_tag_q;
  assign result_data_o  = result_data_q;

  // returns never push the count past the buffer depth
  assert property (@(posedge clk) disable iff (!arst_n_i)
    (credit_return_i && !result_valid_q) |-> (credit_cnt_q < CRED_W'(CREDITS)));

  // a result always has a credit behind it
  assert property (@(posedge clk) disable iff (!arst_n_i)
    result_valid_o |-> (credit_cnt_q != '0));

endmodule : az_result_capture

/* src/az_sequencer.sv */
// auto-zero sequencer
// steps the az mux between hi and lo inputs, moves the pre-charge
// switch around each mux change, releases the adc from reset after
// the settle time and waits for conversion valid
// arm trigger rising edge starts the sequence, falling edge parks it

`timescale 1ns/10ps

module az_sequencer import az_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n_i,

  // static configuration
  input  logic [AZMUX_W-1:0]   azmux_lo_val_i,
  input  logic [AZMUX_W-1:0]   azmux_hi_val_i,
  input  logic [SW_PC_W-1:0]   sw_pc_hi_val_i,
  input  logic [CNT_W-1:0]     settle_count_i,

  input  logic                 arm_trigger_i,
  input  logic                 adc_valid_i,
  input  logic                 slot_free_i,

  output logic                 adc_reset_n_o,
  output logic [AZMUX_W-1:0]   azmux_o,
  output logic [SW_PC_W-1:0]   sw_pc_o,
  output logic                 sample_tag_o
);

  ////////////////////////////////////////////////////////////
  // state encoding

  localparam logic [3:0] ST_PARK     = 4'd0;
  // first boot phase, only on arm
  localparam logic [3:0] ST_BOOT_HI  = 4'd1;
  localparam logic [3:0] ST_MUX_HI   = 4'd2;
  localparam logic [3:0] ST_SIG_HI   = 4'd3;
  localparam logic [3:0] ST_START_HI = 4'd4;
  localparam logic [3:0] ST_CONV_HI  = 4'd5;
  localparam logic [3:0] ST_BOOT_LO  = 4'd6;
  localparam logic [3:0] ST_MUX_LO   = 4'd7;
  localparam logic [3:0] ST_START_LO = 4'd8;
  localparam logic [3:0] ST_CONV_LO  = 4'd9;

  logic [3:0]       state_q;
  logic [CNT_W-1:0] cnt_q;
  logic             settle_done;

  // trigger synchronizer, bit 0 is newest
  logic [1:0]       trig_sync_q;
  logic             trig_rise;
  logic             trig_fall;

  // az mux on the hi input
  logic             mux_hi_q;
  sw_pc_e           sw_pc_q;
  logic             adc_reset_n_q;
  logic             tag_q;

  ////////////////////////////////////////////////////////////
  // trigger sync and edge detect

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      trig_sync_q <= 2'b00;
    else
      trig_sync_q <= {trig_sync_q[0], arm_trigger_i};
  end

  assign trig_rise = trig_sync_q[0] & ~trig_sync_q[1];
  assign trig_fall = ~trig_sync_q[0] & trig_sync_q[1];

  // current phase has held its outputs long enough
  assign settle_done = (cnt_q == '0);

  ////////////////////////////////////////////////////////////
  // main sequence

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q       <= ST_PARK;
      cnt_q         <= '0;
      mux_hi_q      <= 1'b0;
      sw_pc_q       <= SW_PC_BOOT;
      adc_reset_n_q <= 1'b0;
      tag_q         <= SAMPLE_LO;
    end
    else
    begin
      // counter runs down in every phase, reloaded on phase entry
      if (!settle_done)
        cnt_q <= cnt_q - 1'b1;

      case (state_q)
        // pc switch at boot, protect signal before touching az mux
        ST_BOOT_HI:
          if (settle_done)
          begin
            state_q  <= ST_MUX_HI;
            mux_hi_q <= 1'b1;
            cnt_q    <= settle_count_i;
          end

        // az mux now on hi, pre-charge phase
        ST_MUX_HI:
          if (settle_done)
          begin
            state_q <= ST_SIG_HI;
            sw_pc_q <= sw_pc_e'(sw_pc_hi_val_i);
            cnt_q   <= settle_count_i;
          end

        // pc switch to signal, let vos between sig and boot settle
        ST_SIG_HI:
          if (settle_done)
            state_q <= ST_START_HI;

        // hold off until the host has room for the result
        ST_START_HI:
          if (slot_free_i)
          begin
            state_q       <= ST_CONV_HI;
            adc_reset_n_q <= 1'b1;
            tag_q         <= SAMPLE_HI;
          end

        // adc running on hi
        ST_CONV_HI:
          if (adc_valid_i)
          begin
            state_q       <= ST_BOOT_LO;
            adc_reset_n_q <= 1'b0;
            sw_pc_q       <= SW_PC_BOOT;
            cnt_q         <= settle_count_i;
          end

        // back to boot before the mux moves to lo
        ST_BOOT_LO:
          if (settle_done)
          begin
            state_q  <= ST_MUX_LO;
            mux_hi_q <= 1'b0;
            cnt_q    <= settle_count_i;
          end

        // az mux on lo, settle
        ST_MUX_LO:
          if (settle_done)
            state_q <= ST_START_LO;

        ST_START_LO:
          if (slot_free_i)
          begin
            state_q       <= ST_CONV_LO;
            adc_reset_n_q <= 1'b1;
            tag_q         <= SAMPLE_LO;
          end

        // adc running on lo, then loop straight to the hi mux phase
        ST_CONV_LO:
          if (adc_valid_i)
          begin
            state_q       <= ST_MUX_HI;
            adc_reset_n_q <= 1'b0;
            mux_hi_q      <= 1'b1;
            cnt_q         <= settle_count_i;
          end

        // parked, outputs held
        default:
          state_q <= ST_PARK;
      endcase

      // trigger edges override whatever state we are in
      if (trig_rise)
      begin
        state_q       <= ST_BOOT_HI;
        sw_pc_q       <= SW_PC_BOOT;
        adc_reset_n_q <= 1'b0;
        cnt_q         <= settle_count_i;
      end
      else if (trig_fall)
      begin
        state_q       <= ST_PARK;
        adc_reset_n_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // outputs

  assign azmux_o       = mux_hi_q ? azmux_hi_val_i : azmux_lo_val_i;
  assign sw_pc_o       = sw_pc_q;
  assign adc_reset_n_o = adc_reset_n_q;
  assign sample_tag_o  = tag_q;

  // conversion starts with the mux on the input its tag names
  assert property (@(posedge clk) disable iff (!arst_n_i)
    $rose(adc_reset_n_o) |->
      (azmux_o == ((sample_tag_o == SAMPLE_HI) ? azmux_hi_val_i : azmux_lo_val_i)));

  // never start without a host slot
  assert property (@(posedge clk) disable iff (!arst_n_i)
    $rose(adc_reset_n_o) |-> $past(slot_free_i));

endmodule : az_sequencer

/* tb.f */
src/az_pkg.sv
src/az_sequencer.sv
src/az_result_capture.sv
src/az_frontend_top.sv
verif/az_adc_model.sv
verif/tb_az_frontend.sv

/* verif/az_adc_model.sv */
// behavioral adc for the auto-zero front end testbench
// counts a fixed latency after reset release, then raises valid for
// one cycle with a running conversion count as the data word

`timescale 1ns/10ps

module az_adc_model #(
  parameter int DATA_W  = 24,
  parameter int LATENCY = 5
) (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              adc_reset_n_i,
  output logic              adc_valid_o,
  output logic [DATA_W-1:0] adc_data_o
);

  // cycles since reset release
  int                lat_cnt;
  // conversions finished so far
  logic [DATA_W-1:0] conv_cnt;

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      lat_cnt     <= 0;
      conv_cnt    <= '0;
      adc_valid_o <= 1'b0;
      adc_data_o  <= '0;
    end
    else if (!adc_reset_n_i)
    begin
      // held in reset, conversion aborted or done
      lat_cnt     <= 0;
      adc_valid_o <= 1'b0;
    end
    else if (adc_valid_o)
      adc_valid_o <= 1'b0;
    else if (lat_cnt == LATENCY - 1)
    begin
      adc_valid_o <= 1'b1;
      adc_data_o  <= conv_cnt;
      conv_cnt    <= conv_cnt + 1'b1;
    end
    else
      lat_cnt <= lat_cnt + 1;
  end

endmodule : az_adc_model

/* verif/tb_az_frontend.sv */
// testbench for the auto-zero acquisition front end
// each table row resets the DUT with its configuration, arms the
// sequencer, collects tagged results under immediate or random
// credit returns, then parks it and watches for stray conversions

`timescale 1ns/10ps

module tb_az_frontend
  import az_pkg::*;
();

  localparam int DATA_W    = 16;
  localparam int CREDITS   = 3;
  localparam int ADC_LAT   = 5;
  localparam int NUM_TESTS = 4;
  // return delay width, long enough to back up the host buffer
  localparam int DELAY_BITS = 6;

  typedef struct packed {
    int                 settle;
    logic [AZMUX_W-1:0] hi_val;
    logic [AZMUX_W-1:0] lo_val;
    logic [SW_PC_W-1:0] sw_hi;
    int                 n_results;
    logic               delayed;
  } test_row_t;

  test_row_t rows [NUM_TESTS];

  logic               clk           = 1'b0;
  logic               arst_n        = 1'b0;
  logic [AZMUX_W-1:0] azmux_lo_val  = '0;
  logic [AZMUX_W-1:0] azmux_hi_val  = '0;
  logic [SW_PC_W-1:0] sw_pc_hi_val  = '0;
  logic [CNT_W-1:0]   settle_count  = '0;
  logic               arm_trigger   = 1'b0;
  logic               credit_return = 1'b0;
  logic               adc_valid;
  logic [DATA_W-1:0]  adc_data;
  logic               adc_reset_n;
  logic [AZMUX_W-1:0] azmux;
  logic [SW_PC_W-1:0] sw_pc;
  logic               result_valid;
  logic               result_tag;
  logic [DATA_W-1:0]  result_data;

  // scoreboard state, owned by the monitor
  int                 seen;
  int                 outstanding;
  int                 mon_cycle;
  int                 mux_change_at;
  int                 mon_errors  = 0;
  int                 main_errors = 0;
  logic               rise_tag;
  logic               rst_prev;
  logic               exp_tag;
  logic [AZMUX_W-1:0] mux_prev;
  logic [AZMUX_W-1:0] exp_mux;
  logic [SW_PC_W-1:0] exp_sw;

  // host side
  logic [31:0]        lfsr_q       = 32'h9ffc_f31c;
  logic               delayed_mode = 1'b0;
  int                 owed;
  int                 wait_left;

  int                 cycle       = 0;
  int                 cycle_limit = 0;

  always #5 clk = ~clk;

  az_frontend_top #(
    .DATA_W  (DATA_W),
    .CREDITS (CREDITS)
  ) dut_i (
    .clk             (clk),
    .arst_n_i        (arst_n),
    .azmux_lo_val_i  (azmux_lo_val),
    .azmux_hi_val_i  (azmux_hi_val),
    .sw_pc_hi_val_i  (sw_pc_hi_val),
    .settle_count_i  (settle_count),
    .arm_trigger_i   (arm_trigger),
    .adc_valid_i     (adc_valid),
    .adc_data_i      (adc_data),
    .adc_reset_n_o   (adc_reset_n),
    .azmux_o         (azmux),
    .sw_pc_o         (sw_pc),
    .result_valid_o  (result_valid),
    .result_tag_o    (result_tag),
    .result_data_o   (result_data),
    .credit_return_i (credit_return)
  );

  az_adc_model #(
    .DATA_W  (DATA_W),
    .LATENCY (ADC_LAT)
  ) adc_i (
    .clk           (clk),
    .arst_n_i      (arst_n),
    .adc_reset_n_i (adc_reset_n),
    .adc_valid_o   (adc_valid),
    .adc_data_o    (adc_data)
  );

  ////////////////////////////////////////////////////////////
  // helpers

  // fibonacci lfsr, taps 32 22 2 1, new bit enters at bit 0
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // random return delay, one lfsr step per bit
  task automatic draw_delay(output int delay);
    int b;
    delay = 0;
    for (b = 0; b < DELAY_BITS; b++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      delay  = (delay << 1) | int'(lfsr_q[0]);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp, inout int errs);
    assert (got === exp)
    else
    begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errs = errs + 1;
    end
  endtask

  // reset, idle, results at worst-case pace with credit waits and the
  // parked window, doubled
  function automatic int run_limit();
    int total;
    int i;
    int per_result;
    total = 0;
    for (i = 0; i < NUM_TESTS; i++)
    begin
      per_result = 4 * (rows[i].settle + 2) + ADC_LAT + 20;
      if (rows[i].delayed)
        per_result = per_result + (1 << DELAY_BITS);
      total = total + 20 + 4 * (rows[i].settle + 1) + ADC_LAT + 8
            + rows[i].n_results * per_result;
    end
    return 2 * total;
  endfunction

  ////////////////////////////////////////////////////////////
  // host credit return

  // one credit per cycle, optionally spaced by a random delay
  always @(posedge clk)
  begin
    if (!arst_n)
    begin
      owed          = 0;
      wait_left     = 0;
      credit_return <= 1'b0;
    end
    else
    begin
      if (result_valid)
        owed = owed + 1;
      if (wait_left > 0)
      begin
        wait_left     = wait_left - 1;
        credit_return <= 1'b0;
      end
      else if (owed > 0)
      begin
        owed          = owed - 1;
        credit_return <= 1'b1;
        if (delayed_mode)
          draw_delay(wait_left);
      end
      else
        credit_return <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // monitor

  always @(posedge clk)
  begin
    if (!arst_n)
    begin
      seen          = 0;
      outstanding   = 0;
      mon_cycle     = 0;
      mux_change_at = 0;
      rise_tag      = SAMPLE_HI;
      rst_prev      = 1'b0;
      mux_prev      = azmux;
    end
    else
    begin
      mon_cycle = mon_cycle + 1;
      if (azmux != mux_prev)
        mux_change_at = mon_cycle;
      mux_prev = azmux;

      // adc leaves reset, mux and switch must match the coming tag
      if (adc_reset_n && !rst_prev)
      begin
        exp_mux = (rise_tag == SAMPLE_HI) ? azmux_hi_val : azmux_lo_val;
        exp_sw  = SW_PC_BOOT;
        if (rise_tag == SAMPLE_HI)
          exp_sw = sw_pc_hi_val;
        check_value("azmux_o", 32'(azmux), 32'(exp_mux), mon_errors);
        check_value("sw_pc_o", 32'(sw_pc), 32'(exp_sw), mon_errors);
        assert (mon_cycle - mux_change_at >= int'(settle_count) + 1)
        else
        begin
          $display("adc left reset %0d cycles after the az mux moved, settle count is %0d",
                   mon_cycle - mux_change_at, settle_count);
          mon_errors = mon_errors + 1;
        end
        rise_tag = ~rise_tag;
      end
      rst_prev = adc_reset_n;

      // results alternate hi, lo and carry the model's count
      if (result_valid)
      begin
        exp_tag = (seen % 2 == 0) ? SAMPLE_HI : SAMPLE_LO;
        check_value("result_tag_o", 32'(result_tag), 32'(exp_tag), mon_errors);
        check_value("result_data_o", 32'(result_data), 32'(seen), mon_errors);
        seen        = seen + 1;
        outstanding = outstanding + 1;
      end
      if (credit_return)
        outstanding = outstanding - 1;
      assert (outstanding >= 0 && outstanding <= CREDITS)
      else
      begin
        $display("%0d results outstanding, the host buffer holds %0d", outstanding, CREDITS);
        mon_errors = mon_errors + 1;
      end
    end
  end

  // run limit
  always @(posedge clk)
  begin
    cycle = cycle + 1;
    if (cycle > cycle_limit)
    begin
      $display("timeout after %0d cycles, the sequence stopped making progress", cycle);
      $display("Result: FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence

  initial
  begin
    int    i;
    int    n;
    int    window;
    int    err_before;
    int    fails;
    string mode;
    rows[0] = '{settle: 0, hi_val: 4'h1, lo_val: 4'h2, sw_hi: SW_PC_SIGNAL, n_results: 6,
                delayed: 1'b0};
    rows[1] = '{settle: 3, hi_val: 4'h8, lo_val: 4'h4, sw_hi: 2'b10, n_results: 8,
                delayed: 1'b1};
    rows[2] = '{settle: 7, hi_val: 4'h5, lo_val: 4'ha, sw_hi: 2'b11, n_results: 10,
                delayed: 1'b1};
    rows[3] = '{settle: 1, hi_val: 4'hc, lo_val: 4'h3, sw_hi: SW_PC_SIGNAL, n_results: 6,
                delayed: 1'b0};
    cycle_limit = run_limit();
    fails       = 0;

    for (i = 0; i < NUM_TESTS; i++)
    begin
      n          = rows[i].n_results;
      err_before = main_errors + mon_errors;
      // reset with the new configuration
      @(posedge clk);
      arst_n       <= 1'b0;
      arm_trigger  <= 1'b0;
      settle_count <= CNT_W'(rows[i].settle);
      azmux_hi_val <= rows[i].hi_val;
      azmux_lo_val <= rows[i].lo_val;
      sw_pc_hi_val <= rows[i].sw_hi;
      @(negedge clk);
      delayed_mode = rows[i].delayed;
      repeat (4) @(posedge clk);
      arst_n <= 1'b1;

      // parked and idle before any trigger
      repeat (3)
      begin
        @(negedge clk);
        check_value("adc_reset_n_o", 32'(adc_reset_n), 32'd0, main_errors);
        check_value("sw_pc_o", 32'(sw_pc), 32'(SW_PC_BOOT), main_errors);
        check_value("azmux_o", 32'(azmux), 32'(rows[i].lo_val), main_errors);
        check_value("result_valid_o", 32'(result_valid), 32'd0, main_errors);
      end

      @(posedge clk);
      arm_trigger <= 1'b1;
      while (seen < n)
        @(negedge clk);

      // falling edge parks, allow for the synchronizer
      @(posedge clk);
      arm_trigger <= 1'b0;
      repeat (3) @(posedge clk);
      window = 4 * (rows[i].settle + 1) + ADC_LAT + 8;
      repeat (window)
      begin
        @(negedge clk);
        check_value("adc_reset_n_o", 32'(adc_reset_n), 32'd0, main_errors);
        assert (result_valid == 1'b0)
        else
        begin
          $display("a result arrived after the trigger fell in test %0d", i);
          main_errors = main_errors + 1;
        end
      end
      assert (seen == n)
      else
      begin
        $display("test %0d expected %0d results but saw %0d", i, n, seen);
        main_errors = main_errors + 1;
      end

      if (rows[i].delayed)
        mode = "delayed";
      else
        mode = "immediate";
      if (main_errors + mon_errors == err_before)
        $display("test %0d: settle %0d, %0d results, %s credits, pass",
                 i, rows[i].settle, seen, mode);
      else
      begin
        $display("test %0d: settle %0d, %0d results, %s credits, fail",
                 i, rows[i].settle, seen, mode);
        fails = fails + 1;
      end
    end

    $display("summary: %0d tests, %0d failed, %0d errors",
             NUM_TESTS, fails, main_errors + mon_errors);
    if (fails == 0 && main_errors + mon_errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule : tb_az_frontend
